// File: include/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Channel count and internal bus width
`define DMA_CHANNELS 4
`define DMA_DATA_W 8

// Command register bits
`define DMA_CMD_COMPRESSED 3
`define DMA_CMD_EXT_WRITE 5
`define DMA_CMD_DACK_HIGH 7

// Mode register fields
`define DMA_MODE_CH_LSB 0
`define DMA_MODE_TYPE_LSB 2
`define DMA_MODE_AUTOINIT 4
`define DMA_MODE_DECREMENT 5
`define DMA_MODE_MODE_LSB 6

`endif

// File: src/dma_cfg_pkg.sv
`default_nettype none

`include "dma_consts.svh"

package dma_cfg_pkg;

	typedef enum logic [1:0] {
		TT_VERIFY = 2'b00,
		TT_WRITE  = 2'b01,
		TT_READ   = 2'b10
	} transfer_type_e;

	// Cascade code 2'b11 is stored as demand
	typedef enum logic [1:0] {
		TM_DEMAND = 2'b00,
		TM_SINGLE = 2'b01,
		TM_BLOCK  = 2'b10
	} transfer_mode_e;

	typedef struct packed {
		logic compressed;
		logic extended_write;
		logic dack_high;
	} command_t;

	typedef struct packed {
		transfer_type_e ttype;
		logic autoinit;
		logic decrement;
		transfer_mode_e tmode;
	} mode_t;

	typedef mode_t [`DMA_CHANNELS-1:0] mode_array_t;

endpackage

`default_nettype wire

// File: src/dma_bus_pkg.sv
`default_nettype none

package dma_bus_pkg;

	// One state per clock
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		HOLD_WAIT = 3'd1,
		S1        = 3'd2,
		S2        = 3'd3,
		S3        = 3'd4,
		S_WAIT    = 3'd5,
		S4        = 3'd6
	} seq_state_e;

	// Read and write strobes are active low
	typedef struct packed {
		logic memr_n;
		logic memw_n;
		logic ior_n;
		logic iow_n;
		logic aen;
		logic adstb;
	} strobes_t;

endpackage

`default_nettype wire

// File: src/dma_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_config_regs (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     master_clear_i,
	input  wire logic [`DMA_DATA_W-1:0]   data_i,
	input  wire logic                     write_command_i,
	input  wire logic                     write_mode_i,
	output dma_cfg_pkg::command_t         command_o,
	output dma_cfg_pkg::mode_array_t      modes_o
);
	import dma_cfg_pkg::*;

	logic [1:0] mode_channel;
	mode_t written_mode;

	assign mode_channel = data_i[`DMA_MODE_CH_LSB +: 2];

	// Cascade becomes a demand-mode verify, and the unused type code a verify
	always_comb begin
		written_mode.ttype = transfer_type_e'(data_i[`DMA_MODE_TYPE_LSB +: 2]);
		written_mode.autoinit = data_i[`DMA_MODE_AUTOINIT];
		written_mode.decrement = data_i[`DMA_MODE_DECREMENT];
		written_mode.tmode = transfer_mode_e'(data_i[`DMA_MODE_MODE_LSB +: 2]);
		if (data_i[`DMA_MODE_MODE_LSB +: 2] == 2'b11) begin
			written_mode.tmode = TM_DEMAND;
			written_mode.ttype = TT_VERIFY;
		end else if (data_i[`DMA_MODE_TYPE_LSB +: 2] == 2'b11) begin
			written_mode.ttype = TT_VERIFY;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			command_o <= '0;
		end else if (master_clear_i) begin
			command_o <= '0;
		end else if (write_command_i) begin
			command_o.compressed <= data_i[`DMA_CMD_COMPRESSED];
			command_o.extended_write <= data_i[`DMA_CMD_EXT_WRITE];
			command_o.dack_high <= data_i[`DMA_CMD_DACK_HIGH];
		end
	end

	// Only the addressed channel takes a mode write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			modes_o <= '0;
		end else if (master_clear_i) begin
			modes_o <= '0;
		end else if (write_mode_i) begin
			modes_o[mode_channel] <= written_mode;
		end
	end

endmodule

`default_nettype wire

// File: src/dma_priority.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_priority (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       master_clear_i,
	input  wire logic [`DMA_CHANNELS-1:0]   request_i,
	input  wire logic                       served_valid_i,
	input  wire logic [1:0]                 served_channel_i,
	output logic      [`DMA_CHANNELS-1:0]   grant_o
);

	logic [1:0] pointer;

	// Last served channel gets the lowest priority
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pointer <= 2'd3;
		end else if (master_clear_i) begin
			pointer <= 2'd3;
		end else if (served_valid_i) begin
			pointer <= served_channel_i;
		end
	end

	// Search upward from the channel after the pointer
	always_comb begin
		logic [1:0] idx;
		logic found;
		grant_o = '0;
		found = 1'b0;
		for (int i = 1; i <= `DMA_CHANNELS; i++) begin
			idx = pointer + 2'(i);
			if (!found && request_i[idx]) begin
				grant_o[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_sequencer (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       master_clear_i,
	input  wire dma_cfg_pkg::command_t      command_i,
	input  wire dma_cfg_pkg::mode_array_t   modes_i,
	input  wire logic [`DMA_CHANNELS-1:0]   grant_i,
	input  wire logic [`DMA_CHANNELS-1:0]   request_i,
	input  wire logic                       hold_ack_i,
	input  wire logic                       ready_i,
	input  wire logic                       eop_i,
	output logic                            hold_request_o,
	output dma_bus_pkg::seq_state_e         state_o,
	output logic      [`DMA_CHANNELS-1:0]   active_o,
	output logic                            served_valid_o,
	output logic      [1:0]                 served_channel_o,
	output logic                            next_word_o,
	output logic                            decrement_o
);
	import dma_cfg_pkg::*;
	import dma_bus_pkg::*;

	seq_state_e state_q;
	seq_state_e state_d;
	logic [1:0] channel;
	mode_t cur_mode;
	logic word_done;
	logic request_held;

	always_comb begin
		channel = '0;
		for (int i = 0; i < `DMA_CHANNELS; i++) begin
			if (active_o[i]) begin
				channel = 2'(i);
			end
		end
	end

	assign cur_mode = modes_i[channel];
	// A verify cycle never waits for READY
	assign word_done = ready_i || (cur_mode.ttype == TT_VERIFY);
	assign request_held = |(request_i & active_o);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: if (|grant_i) state_d = HOLD_WAIT;
			HOLD_WAIT: if (hold_ack_i) state_d = S1;
			S1: state_d = S2;
			S2: begin
				if (!command_i.compressed) begin
					state_d = S3;
				end else begin
					state_d = word_done ? S4 : S_WAIT;
				end
			end
			S3: state_d = word_done ? S4 : S_WAIT;
			S_WAIT: if (ready_i) state_d = S4;
			S4: begin
				unique case (cur_mode.tmode)
					TM_SINGLE: state_d = IDLE;
					TM_BLOCK: state_d = eop_i ? IDLE : S2;
					default: state_d = (eop_i || !request_held) ? IDLE : S2;
				endcase
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state_q <= IDLE;
			active_o <= '0;
		end else if (master_clear_i) begin
			state_q <= IDLE;
			active_o <= '0;
		end else begin
			state_q <= state_d;
			// Grant is frozen on leaving IDLE
			if (state_q == IDLE) begin
				active_o <= grant_i;
			end
		end
	end

	assign state_o = state_q;
	assign hold_request_o = (state_q != IDLE);
	assign served_valid_o = (state_q == S1);
	assign served_channel_o = channel;
	assign next_word_o = (state_d == S4);
	assign decrement_o = cur_mode.decrement;

endmodule

`default_nettype wire

// File: src/dma_bus_strobes.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_bus_strobes (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       master_clear_i,
	input  wire dma_cfg_pkg::command_t      command_i,
	input  wire dma_cfg_pkg::mode_array_t   modes_i,
	input  wire dma_bus_pkg::seq_state_e    state_i,
	input  wire logic [`DMA_CHANNELS-1:0]   active_i,
	output dma_bus_pkg::strobes_t           strobes_o,
	output logic      [`DMA_CHANNELS-1:0]   dack_o
);
	import dma_cfg_pkg::*;
	import dma_bus_pkg::*;

	localparam strobes_t STROBES_OFF = '{
		memr_n: 1'b1, memw_n: 1'b1, ior_n: 1'b1, iow_n: 1'b1, aen: 1'b0, adstb: 1'b0
	};

	transfer_type_e ttype;
	logic read_start;
	logic write_start;
	logic in_transfer;
	logic [`DMA_CHANNELS-1:0] dack_q;

	always_comb begin
		ttype = TT_VERIFY;
		for (int i = 0; i < `DMA_CHANNELS; i++) begin
			if (active_i[i]) begin
				ttype = modes_i[i].ttype;
			end
		end
	end

	assign read_start = (state_i == S2);
	// Extended write and compressed timing pull the write strobe into S2
	assign write_start = (state_i == S3) ||
		((state_i == S2) && (command_i.extended_write || command_i.compressed));
	assign in_transfer = (state_i == S2) || (state_i == S3) ||
		(state_i == S_WAIT) || (state_i == S4);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			strobes_o <= STROBES_OFF;
			dack_q <= '0;
		end else if (master_clear_i) begin
			strobes_o <= STROBES_OFF;
			dack_q <= '0;
		end else begin
			strobes_o.adstb <= (state_i == S1);
			if (state_i == S1) begin
				strobes_o.aen <= 1'b1;
			end else if (state_i == IDLE) begin
				strobes_o.aen <= 1'b0;
			end
			if (state_i == S4) begin
				strobes_o.memr_n <= 1'b1;
				strobes_o.memw_n <= 1'b1;
				strobes_o.ior_n <= 1'b1;
				strobes_o.iow_n <= 1'b1;
			end else begin
				// Write type moves I/O to memory, read type memory to I/O
				if (read_start && ttype == TT_WRITE) strobes_o.ior_n <= 1'b0;
				if (read_start && ttype == TT_READ) strobes_o.memr_n <= 1'b0;
				if (write_start && ttype == TT_WRITE) strobes_o.memw_n <= 1'b0;
				if (write_start && ttype == TT_READ) strobes_o.iow_n <= 1'b0;
			end
			dack_q <= in_transfer ? active_i : '0;
		end
	end

	assign dack_o = command_i.dack_high ? dack_q : ~dack_q;

endmodule

`default_nettype wire

// File: src/dma_end_of_process.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_end_of_process (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       master_clear_i,
	input  wire dma_cfg_pkg::mode_array_t   modes_i,
	input  wire dma_bus_pkg::seq_state_e    state_i,
	input  wire logic [`DMA_CHANNELS-1:0]   active_i,
	input  wire logic                       next_word_i,
	input  wire logic                       underflow_i,
	input  wire logic                       eop_n_i,
	input  wire logic                       read_status_i,
	output logic                            eop_o,
	output logic                            eop_n_o,
	output logic                            init_current_o,
	output logic      [`DMA_CHANNELS-1:0]   tc_status_o
);
	import dma_bus_pkg::*;

	logic ext_eop_q;
	logic read_status_q;
	logic [`DMA_CHANNELS-1:0] autoinit_set;

	always_comb begin
		for (int i = 0; i < `DMA_CHANNELS; i++) begin
			autoinit_set[i] = modes_i[i].autoinit;
		end
	end

	// Terminal count pulse lines up with S4
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			eop_n_o <= 1'b1;
			ext_eop_q <= 1'b0;
			read_status_q <= 1'b0;
			tc_status_o <= '0;
		end else if (master_clear_i) begin
			eop_n_o <= 1'b1;
			ext_eop_q <= 1'b0;
			read_status_q <= read_status_i;
			tc_status_o <= '0;
		end else begin
			eop_n_o <= !(next_word_i && underflow_i);
			if (state_i == IDLE) begin
				ext_eop_q <= 1'b0;
			end else if (state_i == S2 && !eop_n_i) begin
				ext_eop_q <= 1'b1;
			end
			read_status_q <= read_status_i;
			// Status read ends on the falling edge
			if (read_status_q && !read_status_i) begin
				tc_status_o <= '0;
			end else if (eop_o) begin
				tc_status_o <= tc_status_o | active_i;
			end
		end
	end

	assign eop_o = (state_i == S4) && (!eop_n_o || ext_eop_q);
	assign init_current_o = eop_o && |(autoinit_set & active_i);

endmodule

`default_nettype wire

// File: src/dma_timing_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_timing_control (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       master_clear_i,
	input  wire logic [`DMA_DATA_W-1:0]     data_i,
	input  wire logic                       write_command_i,
	input  wire logic                       write_mode_i,
	input  wire logic                       read_status_i,
	input  wire logic [`DMA_CHANNELS-1:0]   dreq_i,
	input  wire logic                       hold_ack_i,
	input  wire logic                       ready_i,
	input  wire logic                       underflow_i,
	input  wire logic                       eop_n_i,
	output logic                            hold_request_o,
	output dma_bus_pkg::strobes_t           strobes_o,
	output logic      [`DMA_CHANNELS-1:0]   dack_o,
	output logic                            next_word_o,
	output logic                            decrement_o,
	output logic                            eop_n_o,
	output logic                            init_current_o,
	output logic      [`DMA_CHANNELS-1:0]   tc_status_o
);
	import dma_cfg_pkg::*;
	import dma_bus_pkg::*;

	command_t command;
	mode_array_t modes;
	seq_state_e state;
	logic [`DMA_CHANNELS-1:0] grant;
	logic [`DMA_CHANNELS-1:0] active;
	logic served_valid;
	logic [1:0] served_channel;
	logic eop;

	dma_config_regs i_config_regs (
		.clock, .reset, .master_clear_i, .data_i, .write_command_i, .write_mode_i,
		.command_o(command), .modes_o(modes)
	);

	dma_priority i_priority (
		.clock, .reset, .master_clear_i, .request_i(dreq_i),
		.served_valid_i(served_valid), .served_channel_i(served_channel), .grant_o(grant)
	);

	dma_sequencer i_sequencer (
		.clock, .reset, .master_clear_i, .command_i(command), .modes_i(modes),
		.grant_i(grant), .request_i(dreq_i), .hold_ack_i, .ready_i, .eop_i(eop),
		.hold_request_o, .state_o(state), .active_o(active), .served_valid_o(served_valid),
		.served_channel_o(served_channel), .next_word_o, .decrement_o
	);

	dma_bus_strobes i_bus_strobes (
		.clock, .reset, .master_clear_i, .command_i(command), .modes_i(modes),
		.state_i(state), .active_i(active), .strobes_o, .dack_o
	);

	dma_end_of_process i_end_of_process (
		.clock, .reset, .master_clear_i, .modes_i(modes), .state_i(state),
		.active_i(active), .next_word_i(next_word_o), .underflow_i, .eop_n_i,
		.read_status_i, .eop_o(eop), .eop_n_o, .init_current_o, .tc_status_o
	);

endmodule

`default_nettype wire

// File: testbench/tb_dma_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module tb_dma_timing;
	import dma_bus_pkg::*;

	typedef struct packed {
		logic [7:0] command;
		logic [7:0] mode;
		logic [3:0] req;
		logic [3:0] words;
		logic [3:0] uf_word;
		logic [3:0] ready_low;
		logic [7:0] exp_words;
		logic [3:0] exp_low;
		logic       exp_dack;
		logic [3:0] exp_status;
	} case_t;

	localparam int NUM_CASES = 9;

	// command, mode without channel, requests, words per device, underflow word,
	// READY-low cycles, next_word count, strobes low {memr memw ior iow}, DACK level, status
	case_t cases [NUM_CASES] = '{
		'{8'h00, 8'h44, 4'b0001, 4'd1, 4'd0, 4'd0, 8'd1, 4'b0110, 1'b0, 4'b0000},
		'{8'h00, 8'h48, 4'b0100, 4'd1, 4'd0, 4'd0, 8'd1, 4'b1001, 1'b0, 4'b0000},
		'{8'h00, 8'h40, 4'b0010, 4'd1, 4'd0, 4'd0, 8'd1, 4'b0000, 1'b0, 4'b0000},
		'{8'h00, 8'h88, 4'b1000, 4'd4, 4'd4, 4'd0, 8'd4, 4'b1001, 1'b0, 4'b1000},
		'{8'h00, 8'h84, 4'b0010, 4'd3, 4'd3, 4'd2, 8'd3, 4'b0110, 1'b0, 4'b0010},
		'{8'h08, 8'h88, 4'b0001, 4'd3, 4'd3, 4'd0, 8'd3, 4'b1001, 1'b0, 4'b0001},
		'{8'h80, 8'h44, 4'b0110, 4'd2, 4'd0, 4'd0, 8'd4, 4'b0110, 1'b1, 4'b0000},
		'{8'h00, 8'h24, 4'b0100, 4'd3, 4'd0, 4'd0, 8'd3, 4'b0110, 1'b0, 4'b0000},
		'{8'h00, 8'h14, 4'b0010, 4'd2, 4'd2, 4'd0, 8'd2, 4'b0110, 1'b0, 4'b0010}
	};

	logic clock;
	logic reset;
	logic master_clear;
	logic [`DMA_DATA_W-1:0] data;
	logic write_command;
	logic write_mode;
	logic read_status;
	logic [`DMA_CHANNELS-1:0] dreq;
	logic hold_ack;
	logic ready;
	logic underflow;
	logic eop_n_in;
	logic hold_request;
	strobes_t strobes;
	logic [`DMA_CHANNELS-1:0] dack;
	logic next_word;
	logic decrement;
	logic eop_n;
	logic init_current;
	logic [`DMA_CHANNELS-1:0] tc_status;

	case_t cur;
	integer seed;
	int errors;
	int checks;
	int hold_delay;
	int cycle_now;
	int last_word_cycle;
	int service_words;
	int word_count;
	int eop_lows;
	int strobe_cycles;
	int words_left [`DMA_CHANNELS];
	logic [1:0] expected_ch;
	logic [1:0] model_ptr;
	logic prev_hrq;
	logic check_pending;
	logic pending_uf;

	dma_timing_control i_dut (
		.clock(clock), .reset(reset), .master_clear_i(master_clear), .data_i(data),
		.write_command_i(write_command), .write_mode_i(write_mode),
		.read_status_i(read_status), .dreq_i(dreq), .hold_ack_i(hold_ack), .ready_i(ready),
		.underflow_i(underflow), .eop_n_i(eop_n_in), .hold_request_o(hold_request),
		.strobes_o(strobes), .dack_o(dack), .next_word_o(next_word),
		.decrement_o(decrement), .eop_n_o(eop_n), .init_current_o(init_current),
		.tc_status_o(tc_status)
	);

	always #4 clock = ~clock;

	// First requesting channel above the pointer, wrapping around
	function automatic int first_after(input logic [1:0] ptr, input logic [3:0] mask);
		int ch;
		int steps;
		ch = (int'(ptr) + 1) % `DMA_CHANNELS;
		steps = 0;
		while (!mask[ch] && steps < `DMA_CHANNELS - 1) begin
			ch = (ch + 1) % `DMA_CHANNELS;
			steps++;
		end
		return ch;
	endfunction

	// Cycles from one next_word to the next inside a service
	function automatic int word_period(input case_t c);
		int base;
		base = c.command[`DMA_CMD_COMPRESSED] ? 2 : 3;
		return base + int'(c.ready_low);
	endfunction

	function automatic int cycle_limit();
		int total;
		total = 0;
		for (int r = 0; r < NUM_CASES; r++) begin
			total += int'(cases[r].exp_words) * 6 + 50;
		end
		return total;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// Request source, hold acknowledge, slow device and word counter
	always @(posedge clock) begin
		logic [3:0] served;
		logic [3:0] dack_exp;
		if (!reset) begin
			cycle_now = cycle_now + 1;
			if (!hold_request) begin
				hold_ack <= 1'b0;
				hold_delay <= $unsigned($random(seed)) % 4;
			end else if (!hold_ack) begin
				if (hold_delay == 0) begin
					hold_ack <= 1'b1;
				end else begin
					hold_delay <= hold_delay - 1;
				end
			end
			if (!hold_request && dreq != 0) begin
				expected_ch <= 2'(first_after(model_ptr, dreq));
				model_ptr <= 2'(first_after(model_ptr, dreq));
			end
			if (prev_hrq && !hold_request) begin
				if (cur.mode[`DMA_MODE_MODE_LSB +: 2] == 2'b01) begin
					check_value("next_word_o per single service", service_words, 1);
				end
				service_words <= 0;
			end
			prev_hrq <= hold_request;
			// Strobes, DACK and EOP are checked in the S4 cycle
			if (check_pending) begin
				served = 4'b0001 << expected_ch;
				dack_exp = cur.exp_dack ? served : ~served;
				check_value("strobes_o low set",
					{!strobes.memr_n, !strobes.memw_n, !strobes.ior_n, !strobes.iow_n},
					cur.exp_low);
				check_value("strobes_o.aen", strobes.aen, 1'b1);
				check_value("dack_o", dack, dack_exp);
				check_value("decrement_o", decrement, cur.mode[`DMA_MODE_DECREMENT]);
				check_value("eop_n_o", eop_n, !pending_uf);
				check_value("init_current_o", init_current,
					pending_uf && cur.mode[`DMA_MODE_AUTOINIT]);
			end
			if (!eop_n) begin
				eop_lows <= eop_lows + 1;
			end
			check_pending <= next_word;
			if (next_word) begin
				if (service_words > 0) begin
					check_value("next_word_o period", cycle_now - last_word_cycle,
						word_period(cur));
				end
				last_word_cycle <= cycle_now;
				service_words <= service_words + 1;
				word_count <= word_count + 1;
				pending_uf <= underflow;
				words_left[expected_ch] <= words_left[expected_ch] - 1;
				if (words_left[expected_ch] == 1) begin
					dreq[expected_ch] <= 1'b0;
				end
				underflow <= (int'(cur.uf_word) == word_count + 2);
			end
			// Device holds READY low for a set number of read-strobe cycles
			if (!strobes.memr_n || !strobes.ior_n) begin
				strobe_cycles <= strobe_cycles + 1;
				ready <= (strobe_cycles + 1 >= int'(cur.ready_low));
			end else begin
				strobe_cycles <= 0;
				ready <= (cur.ready_low == 4'd0);
			end
		end
	end

	task automatic run_case(input case_t c);
		master_clear <= 1'b1;
		cur <= c;
		model_ptr <= 2'd3;
		word_count <= 0;
		eop_lows <= 0;
		@(posedge clock);
		master_clear <= 1'b0;
		data <= c.command;
		write_command <= 1'b1;
		@(posedge clock);
		write_command <= 1'b0;
		for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
			if (c.req[ch]) begin
				data <= c.mode | 8'(ch);
				write_mode <= 1'b1;
				@(posedge clock);
			end
		end
		write_mode <= 1'b0;
		for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
			words_left[ch] <= c.req[ch] ? int'(c.words) : 0;
		end
		underflow <= (c.uf_word == 4'd1);
		dreq <= c.req;
		@(posedge clock);
		while (dreq != 0 || hold_request) begin
			@(posedge clock);
		end
		check_value("next_word_o count", word_count, c.exp_words);
		check_value("eop_n_o low cycles", eop_lows, c.uf_word != 4'd0);
		check_value("tc_status_o", tc_status, c.exp_status);
		// Status clears on the falling edge of the read
		read_status <= 1'b1;
		@(posedge clock);
		read_status <= 1'b0;
		@(posedge clock);
		@(posedge clock);
		check_value("tc_status_o after read", tc_status, 4'b0000);
	endtask

	initial begin
		seed = 32'h062866c5;
		errors = 0;
		checks = 0;
		cycle_now = 0;
		last_word_cycle = 0;
		service_words = 0;
		word_count = 0;
		eop_lows = 0;
		strobe_cycles = 0;
		hold_delay = 0;
		cur = '0;
		expected_ch = 2'd0;
		model_ptr = 2'd3;
		prev_hrq = 1'b0;
		check_pending = 1'b0;
		pending_uf = 1'b0;
		for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
			words_left[ch] = 0;
		end
		clock = 1'b0;
		reset = 1'b1;
		master_clear = 1'b0;
		data = '0;
		write_command = 1'b0;
		write_mode = 1'b0;
		read_status = 1'b0;
		dreq = '0;
		hold_ack = 1'b0;
		ready = 1'b1;
		underflow = 1'b0;
		eop_n_in = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value("hold_request_o", hold_request, 1'b0);
		check_value("strobes_o", strobes, 6'b111100);
		check_value("dack_o", dack, 4'hf);
		check_value("tc_status_o", tc_status, 4'h0);
		check_value("eop_n_o", eop_n, 1'b1);
		for (int r = 0; r < NUM_CASES; r++) begin
			run_case(cases[r]);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin : watchdog
		int limit;
		int count;
		limit = cycle_limit();
		count = 0;
		while (count < limit) begin
			@(posedge clock);
			count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
src/dma_cfg_pkg.sv
src/dma_bus_pkg.sv
src/dma_config_regs.sv
src/dma_priority.sv
src/dma_sequencer.sv
src/dma_bus_strobes.sv
src/dma_end_of_process.sv
src/dma_timing_control.sv
testbench/tb_dma_timing.sv

// File: Bender.yml
package:
  name: dma_timing

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/dma_cfg_pkg.sv
      - src/dma_bus_pkg.sv
      - src/dma_config_regs.sv
      - src/dma_priority.sv
      - src/dma_sequencer.sv
      - src/dma_bus_strobes.sv
      - src/dma_end_of_process.sv
      - src/dma_timing_control.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_dma_timing.sv
